// File: hdl/tenant_pkg.sv
`default_nettype none

package tenant_pkg;

    localparam int num_tenants = 4;
    localparam int tenant_bits = 2;

    localparam int addr_bits = 32;
    localparam int data_bits = 64;
    localparam int tag_bits  = 16;

    // each arbiter queue is a power of two deep so its pointers wrap on their own
    localparam int queue_depth    = 4;
    localparam int queue_ptr_bits = $clog2(queue_depth);
    localparam int queue_cnt_bits = $clog2(queue_depth + 1);

    // bank swizzle exchanges two address fields of swz_width bits
    localparam int swz_lo_a  = 16;
    localparam int swz_lo_b  = 24;
    localparam int swz_width = 4;

    typedef logic [addr_bits-1:0]   line_addr_t;
    typedef logic [data_bits-1:0]   line_data_t;

    // after the audit the top tenant_bits bits of the tag carry the tenant number
    typedef logic [tag_bits-1:0]    req_tag_t;
    typedef logic [tenant_bits-1:0] tenant_id_t;

    typedef enum logic [1:0]
    {
        kind_read  = 2'd0,
        kind_write = 2'd1,
        kind_fence = 2'd2
    } req_kind_t;

endpackage

`default_nettype wire

// File: hdl/tenant_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// one audited request per cycle with valid high, the consumer has no way to stall it
interface tenant_req_if import tenant_pkg::*; ();

    logic       valid;
    req_kind_t  kind;
    line_addr_t addr;
    line_data_t data;
    req_tag_t   tag;

    modport producer
    (
        output valid, kind, addr, data, tag
    );

    modport consumer
    (
        input valid, kind, addr, data, tag
    );

endinterface

`default_nettype wire

// File: hdl/offset_table.sv
`timescale 1ns/1ps
`default_nettype none

module offset_table import tenant_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cfg_valid,
    input  tenant_id_t cfg_tenant,
    input  line_addr_t cfg_offset,
    output line_addr_t offsets [num_tenants]
);

    logic [num_tenants-1:0] load;

    // decode the strobe into one load enable per tenant
    always_comb
    begin
        load = '0;
        if (cfg_valid)
        begin
            load[cfg_tenant] = 1'b1;
        end
    end

    // a request sampled on the same edge as a write still sees the old base
    for (genvar t = 0; t < num_tenants; t++)
    begin : g_base
        always_ff @(posedge clk or negedge arst_n)
        begin
            if (!arst_n)
            begin
                offsets[t] <= '0;
            end
            else if (load[t])
            begin
                offsets[t] <= cfg_offset;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/tenant_tx_audit.sv
`timescale 1ns/1ps
`default_nettype none

module tenant_tx_audit import tenant_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic [num_tenants-1:0] req_valid,
    input  req_kind_t              req_kind [num_tenants],
    input  line_addr_t             req_addr [num_tenants],
    input  line_data_t             req_data [num_tenants],
    input  req_tag_t               req_tag  [num_tenants],
    input  line_addr_t             offsets  [num_tenants],
    tenant_req_if.producer         audited  [num_tenants]
);

    for (genvar t = 0; t < num_tenants; t++)
    begin : g_tenant
        logic       s1_valid;
        req_kind_t  s1_kind;
        line_addr_t s1_addr;
        line_data_t s1_data;
        req_tag_t   s1_tag;
        line_addr_t s1_offset;

        logic       s2_valid;
        req_kind_t  s2_kind;
        line_addr_t s2_addr;
        line_data_t s2_data;
        req_tag_t   s2_tag;

        line_addr_t swz_addr;

        always_ff @(posedge clk or negedge arst_n)
        begin
            if (!arst_n)
            begin
                s1_valid <= 1'b0;
                s2_valid <= 1'b0;
            end
            else
            begin
                s1_valid <= req_valid[t];
                s2_valid <= s1_valid;
            end
        end

        // stage one captures the request along with the base it must use
        always_ff @(posedge clk)
        begin
            if (req_valid[t])
            begin
                s1_kind   <= req_kind[t];
                s1_addr   <= req_addr[t];
                s1_data   <= req_data[t];
                s1_tag    <= req_tag[t];
                s1_offset <= offsets[t];
            end
        end

        // fences carry no address, so they skip relocation entirely
        always_ff @(posedge clk)
        begin
            if (s1_valid)
            begin
                s2_kind <= s1_kind;
                s2_data <= s1_data;
                s2_addr <= (s1_kind == kind_fence) ? '0 : s1_addr + s1_offset;
                s2_tag  <= {tenant_id_t'(t), s1_tag[tag_bits-tenant_bits-1:0]};
            end
        end

        // exchange the two bank fields on the way out
        always_comb
        begin
            swz_addr = s2_addr;
            swz_addr[swz_lo_a +: swz_width] = s2_addr[swz_lo_b +: swz_width];
            swz_addr[swz_lo_b +: swz_width] = s2_addr[swz_lo_a +: swz_width];
        end

        assign audited[t].valid = s2_valid;
        assign audited[t].kind  = s2_kind;
        assign audited[t].addr  = swz_addr;
        assign audited[t].data  = s2_data;
        assign audited[t].tag   = s2_tag;
    end

endmodule

`default_nettype wire

// File: hdl/upstream_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module upstream_arbiter import tenant_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    tenant_req_if.consumer audited [num_tenants],
    output logic           up_valid,
    output req_kind_t      up_kind,
    output line_addr_t     up_addr,
    output line_data_t     up_data,
    output req_tag_t       up_tag,
    output logic           overflow
);

    logic [num_tenants-1:0] not_empty;
    logic [num_tenants-1:0] drop;

    req_kind_t  head_kind [num_tenants];
    line_addr_t head_addr [num_tenants];
    line_data_t head_data [num_tenants];
    req_tag_t   head_tag  [num_tenants];

    tenant_id_t rr_last;
    logic       grant_valid;
    tenant_id_t grant_id;

    for (genvar t = 0; t < num_tenants; t++)
    begin : g_queue
        req_kind_t  mem_kind [queue_depth];
        line_addr_t mem_addr [queue_depth];
        line_data_t mem_data [queue_depth];
        req_tag_t   mem_tag  [queue_depth];

        logic [queue_ptr_bits-1:0] wr_ptr;
        logic [queue_ptr_bits-1:0] rd_ptr;
        logic [queue_cnt_bits-1:0] count;
        logic                      full;
        logic                      push;
        logic                      pop;

        // nothing upstream can stall us, so a request into a full queue is lost
        assign full         = (count == queue_cnt_bits'(queue_depth));
        assign push         = audited[t].valid && !full;
        assign drop[t]      = audited[t].valid && full;
        assign pop          = grant_valid && (grant_id == tenant_id_t'(t));
        assign not_empty[t] = (count != '0);

        always_ff @(posedge clk or negedge arst_n)
        begin
            if (!arst_n)
            begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end
            else
            begin
                if (push)
                begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (pop)
                begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
                count <= count + queue_cnt_bits'(push) - queue_cnt_bits'(pop);
            end
        end

        always_ff @(posedge clk)
        begin
            if (push)
            begin
                mem_kind[wr_ptr] <= audited[t].kind;
                mem_addr[wr_ptr] <= audited[t].addr;
                mem_data[wr_ptr] <= audited[t].data;
                mem_tag[wr_ptr]  <= audited[t].tag;
            end
        end

        assign head_kind[t] = mem_kind[rd_ptr];
        assign head_addr[t] = mem_addr[rd_ptr];
        assign head_data[t] = mem_data[rd_ptr];
        assign head_tag[t]  = mem_tag[rd_ptr];
    end

    // search starts just after the last winner, so it is considered last
    always_comb
    begin
        tenant_id_t cand;
        grant_valid = 1'b0;
        grant_id    = rr_last;
        for (int i = 1; i <= num_tenants; i++)
        begin
            cand = tenant_id_t'((int'(rr_last) + i) % num_tenants);
            if (!grant_valid && not_empty[cand])
            begin
                grant_valid = 1'b1;
                grant_id    = cand;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            up_valid <= 1'b0;
            rr_last  <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            up_valid <= grant_valid;
            if (grant_valid)
            begin
                rr_last <= grant_id;
            end
            if (|drop)
            begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (grant_valid)
        begin
            up_kind <= head_kind[grant_id];
            up_addr <= head_addr[grant_id];
            up_data <= head_data[grant_id];
            up_tag  <= head_tag[grant_id];
        end
    end

endmodule

`default_nettype wire

// File: hdl/rsp_router.sv
`timescale 1ns/1ps
`default_nettype none

module rsp_router import tenant_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   rsp_valid,
    input  req_tag_t               rsp_tag,
    input  line_data_t             rsp_data,
    output logic [num_tenants-1:0] ten_rsp_valid,
    output req_tag_t               ten_rsp_tag,
    output line_data_t             ten_rsp_data
);

    tenant_id_t             owner;
    logic [num_tenants-1:0] owner_hot;

    // the audit stamped the owner into the top of the tag
    assign owner = rsp_tag[tag_bits-1 -: tenant_bits];

    always_comb
    begin
        owner_hot = '0;
        if (rsp_valid)
        begin
            owner_hot[owner] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            ten_rsp_valid <= '0;
        end
        else
        begin
            ten_rsp_valid <= owner_hot;
        end
    end

    // tenants get back the tag they issued, without the owner field
    always_ff @(posedge clk)
    begin
        if (rsp_valid)
        begin
            ten_rsp_tag  <= {{tenant_bits{1'b0}}, rsp_tag[tag_bits-tenant_bits-1:0]};
            ten_rsp_data <= rsp_data;
        end
    end

endmodule

`default_nettype wire

// File: hdl/tenant_shell.sv
`timescale 1ns/1ps
`default_nettype none

module tenant_shell import tenant_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,

    input  logic                   cfg_valid,
    input  tenant_id_t             cfg_tenant,
    input  line_addr_t             cfg_offset,

    input  logic [num_tenants-1:0] req_valid,
    input  req_kind_t              req_kind [num_tenants],
    input  line_addr_t             req_addr [num_tenants],
    input  line_data_t             req_data [num_tenants],
    input  req_tag_t               req_tag  [num_tenants],

    output logic                   up_valid,
    output req_kind_t              up_kind,
    output line_addr_t             up_addr,
    output line_data_t             up_data,
    output req_tag_t               up_tag,
    output logic                   overflow,

    input  logic                   rsp_valid,
    input  req_tag_t               rsp_tag,
    input  line_data_t             rsp_data,
    output logic [num_tenants-1:0] ten_rsp_valid,
    output req_tag_t               ten_rsp_tag,
    output line_data_t             ten_rsp_data
);

    line_addr_t offsets [num_tenants];

    tenant_req_if audited [num_tenants] ();

    offset_table u_offset_table
    (
        .clk        (clk),
        .arst_n     (arst_n),
        .cfg_valid  (cfg_valid),
        .cfg_tenant (cfg_tenant),
        .cfg_offset (cfg_offset),
        .offsets    (offsets)
    );

    tenant_tx_audit u_tx_audit
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req_kind  (req_kind),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .req_tag   (req_tag),
        .offsets   (offsets),
        .audited   (audited)
    );

    upstream_arbiter u_arbiter
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .audited  (audited),
        .up_valid (up_valid),
        .up_kind  (up_kind),
        .up_addr  (up_addr),
        .up_data  (up_data),
        .up_tag   (up_tag),
        .overflow (overflow)
    );

    rsp_router u_rsp_router
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .rsp_valid     (rsp_valid),
        .rsp_tag       (rsp_tag),
        .rsp_data      (rsp_data),
        .ten_rsp_valid (ten_rsp_valid),
        .ten_rsp_tag   (ten_rsp_tag),
        .ten_rsp_data  (ten_rsp_data)
    );

endmodule

`default_nettype wire

// File: verification/tenant_shell_chk.sv
`timescale 1ns/1ps
`default_nettype none

module tenant_shell_chk import tenant_pkg::*;
(
    input logic                   clk,
    input logic                   arst_n,
    input logic                   up_valid,
    input req_kind_t              up_kind,
    input line_addr_t             up_addr,
    input logic                   overflow,
    input logic                   rsp_valid,
    input line_data_t             rsp_data,
    input logic [num_tenants-1:0] ten_rsp_valid,
    input line_data_t             ten_rsp_data
);

    int unsigned fails = 0;

    // the first edge after reset is released still sees every output idle
    a_reset_idle: assert property (@(posedge clk)
        $rose(arst_n) |-> !up_valid && !overflow && ten_rsp_valid == '0)
    else
    begin
        $error("outputs were not idle when reset was released");
        fails++;
    end

    a_fence_zero: assert property (@(posedge clk) disable iff (!arst_n)
        up_valid && up_kind == kind_fence |-> up_addr == '0)
    else
    begin
        $error("a fence left with a nonzero address");
        fails++;
    end

    a_overflow_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        overflow |=> overflow)
    else
    begin
        $error("overflow dropped before a reset");
        fails++;
    end

    // no tenant sees a response unless one came in the cycle before
    a_rsp_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !rsp_valid |=> ten_rsp_valid == '0)
    else
    begin
        $error("a tenant saw a response that was never sent");
        fails++;
    end

    // responses come back exactly one cycle later with the data untouched
    a_rsp_latency: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |=> ten_rsp_valid != '0 && ten_rsp_data == $past(rsp_data))
    else
    begin
        $error("a response was not returned one cycle later with its data");
        fails++;
    end

endmodule

`default_nettype wire

// File: verification/tb_tenant_shell.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tenant_shell import tenant_pkg::*; ();

    localparam int clk_period  = 20;
    localparam int test_budget = 60;
    localparam int num_tests   = 7;

    typedef struct packed
    {
        req_kind_t  kind;
        line_addr_t addr;
        line_data_t data;
        req_tag_t   tag;
    } up_req_t;

    typedef struct packed
    {
        logic [num_tenants-1:0] valid;
        req_tag_t               tag;
        line_data_t             data;
    } rsp_t;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   cfg_valid;
    tenant_id_t             cfg_tenant;
    line_addr_t             cfg_offset;
    logic [num_tenants-1:0] req_valid;
    req_kind_t              req_kind [num_tenants];
    line_addr_t             req_addr [num_tenants];
    line_data_t             req_data [num_tenants];
    req_tag_t               req_tag  [num_tenants];
    logic                   up_valid;
    req_kind_t              up_kind;
    line_addr_t             up_addr;
    line_data_t             up_data;
    req_tag_t               up_tag;
    logic                   overflow;
    logic                   rsp_valid;
    req_tag_t               rsp_tag;
    line_data_t             rsp_data;
    logic [num_tenants-1:0] ten_rsp_valid;
    req_tag_t               ten_rsp_tag;
    line_data_t             ten_rsp_data;

    integer     seed = 32'hc03e_bae8;
    line_addr_t offs [num_tenants];
    line_addr_t new_off;
    up_req_t    exp_up [num_tenants][$];
    rsp_t       exp_rsp [$];
    logic       track;
    string      test_name;
    int         errors;
    int         fails_before;
    int         tests_run;
    int         tests_failed;

    tenant_shell u_dut (.*);

    bind tenant_shell tenant_shell_chk u_chk
    (
        .clk           (clk),
        .arst_n        (arst_n),
        .up_valid      (up_valid),
        .up_kind       (up_kind),
        .up_addr       (up_addr),
        .overflow      (overflow),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .ten_rsp_valid (ten_rsp_valid),
        .ten_rsp_data  (ten_rsp_data)
    );

    initial
    begin
        forever
        begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    initial
    begin
        #((num_tests * (test_budget + 20) + 50) * clk_period);
        $display("watchdog expired before the tests completed");
        $display("Verification failed");
        $finish;
    end

    // relocate unless fenced, swap the bank fields, stamp the tenant into the tag
    function automatic up_req_t expect_up(int t, req_kind_t k, line_addr_t a,
                                          line_data_t d, req_tag_t g);
        up_req_t    r;
        line_addr_t moved;
        moved  = (k == kind_fence) ? '0 : a + offs[t];
        r.kind = k;
        r.data = d;
        r.addr = moved;
        r.addr[swz_lo_a +: swz_width] = moved[swz_lo_b +: swz_width];
        r.addr[swz_lo_b +: swz_width] = moved[swz_lo_a +: swz_width];
        r.tag  = {tenant_id_t'(t), g[tag_bits-tenant_bits-1:0]};
        return r;
    endfunction

    function automatic int pending();
        int n;
        n = exp_rsp.size();
        for (int t = 0; t < num_tenants; t++)
        begin
            n += exp_up[t].size();
        end
        return n;
    endfunction

    function automatic int total_fails();
        return errors + int'(u_dut.u_chk.fails);
    endfunction

    task automatic issue(logic [num_tenants-1:0] mask, req_kind_t k);
        for (int t = 0; t < num_tenants; t++)
        begin
            if (mask[t])
            begin
                req_kind[t] = k;
                req_addr[t] = line_addr_t'($random(seed));
                req_data[t] = {$random(seed), $random(seed)};
                req_tag[t]  = req_tag_t'($random(seed));
                if (track)
                begin
                    exp_up[t].push_back(expect_up(t, k, req_addr[t], req_data[t],
                                                  req_tag[t]));
                end
            end
        end
        req_valid = mask;
        @(negedge clk);
        req_valid = '0;
    endtask

    task automatic set_offset(int t, line_addr_t value);
        cfg_valid  = 1'b1;
        cfg_tenant = tenant_id_t'(t);
        cfg_offset = value;
        @(negedge clk);
        cfg_valid = 1'b0;
        offs[t]   = value;
    endtask

    task automatic send_rsp(int t);
        rsp_t r;
        rsp_valid = 1'b1;
        rsp_data  = {$random(seed), $random(seed)};
        rsp_tag   = req_tag_t'($random(seed));
        rsp_tag[tag_bits-1 -: tenant_bits] = tenant_id_t'(t);
        r.valid    = '0;
        r.valid[t] = 1'b1;
        r.tag      = rsp_tag;
        r.tag[tag_bits-1 -: tenant_bits] = '0;
        r.data     = rsp_data;
        exp_rsp.push_back(r);
        @(negedge clk);
        rsp_valid = 1'b0;
    endtask

    task automatic watch_outputs();
        tenant_id_t owner;
        up_req_t    got_up;
        up_req_t    want_up;
        rsp_t       got_rsp;
        rsp_t       want_rsp;
        forever
        begin
            @(negedge clk);
            if (track && up_valid)
            begin
                owner  = up_tag[tag_bits-1 -: tenant_bits];
                got_up = {up_kind, up_addr, up_data, up_tag};
                if (exp_up[owner].size() == 0)
                begin
                    $display("%s: unexpected upstream request, tag %h", test_name, up_tag);
                    errors++;
                end
                else
                begin
                    want_up = exp_up[owner].pop_front();
                    a_up_match: assert (got_up == want_up)
                    else
                    begin
                        $display("Error %s: expected %h, got %h", test_name, want_up, got_up);
                        errors++;
                    end
                end
            end
            if (ten_rsp_valid != '0)
            begin
                got_rsp = {ten_rsp_valid, ten_rsp_tag, ten_rsp_data};
                if (exp_rsp.size() == 0)
                begin
                    $display("%s: response routed with none outstanding", test_name);
                    errors++;
                end
                else
                begin
                    want_rsp = exp_rsp.pop_front();
                    a_rsp_match: assert (got_rsp == want_rsp)
                    else
                    begin
                        $display("Error %s: expected %h, got %h", test_name, want_rsp, got_rsp);
                        errors++;
                    end
                end
            end
        end
    endtask

    task automatic start_test(string name);
        test_name    = name;
        fails_before = total_fails();
    endtask

    task automatic finish_test();
        int waited;
        waited = 0;
        while (pending() != 0 && waited < test_budget)
        begin
            @(negedge clk);
            waited++;
        end
        if (pending() != 0)
        begin
            $display("%s: %0d expected transfers never appeared", test_name, pending());
            errors++;
            foreach (exp_up[t])
            begin
                exp_up[t].delete();
            end
            exp_rsp.delete();
        end
        repeat (2) @(negedge clk);
        tests_run++;
        if (total_fails() == fails_before)
        begin
            $display("test %s: pass", test_name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: FAIL", test_name);
        end
    endtask

    initial
    begin
        arst_n     = 1'b0;
        cfg_valid  = 1'b0;
        cfg_tenant = '0;
        cfg_offset = '0;
        req_valid  = '0;
        rsp_valid  = 1'b0;
        rsp_tag    = '0;
        rsp_data   = '0;
        foreach (req_kind[t])
        begin
            req_kind[t] = kind_read;
            req_addr[t] = '0;
            req_data[t] = '0;
            req_tag[t]  = '0;
            offs[t]     = '0;
        end
        track        = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        fork
            watch_outputs();
        join_none
        repeat (3) @(negedge clk);
        arst_n = 1'b1;

        start_test("reset");
        a_reset_idle: assert (!up_valid && !overflow && ten_rsp_valid == '0)
        else
        begin
            $display("Error reset: expected 0, got %b", {up_valid, overflow, ten_rsp_valid});
            errors++;
        end
        finish_test();

        start_test("relocate");
        for (int t = 0; t < num_tenants; t++)
        begin
            set_offset(t, line_addr_t'($random(seed)));
        end
        for (int t = 0; t < num_tenants; t++)
        begin
            issue(num_tenants'(1 << t), kind_read);
            issue(num_tenants'(1 << t), kind_write);
        end
        finish_test();

        start_test("fence");
        issue('1, kind_fence);
        finish_test();

        // four back-to-back rounds from every tenant exactly fill the queues
        start_test("concurrent");
        repeat (2)
        begin
            issue('1, kind_write);
            issue('1, kind_read);
        end
        repeat (4) @(negedge clk);
        a_no_overflow: assert (!overflow)
        else
        begin
            $display("Error concurrent: expected overflow 0, got %b", overflow);
            errors++;
        end
        finish_test();

        // the request beside the write still uses the old base
        start_test("offset_update");
        new_off = line_addr_t'($random(seed));
        fork
            set_offset(2, new_off);
            issue(4'b0100, kind_read);
        join
        issue(4'b0100, kind_write);
        finish_test();

        start_test("response");
        for (int t = 0; t < num_tenants; t++)
        begin
            send_rsp(t);
        end
        send_rsp(1);
        finish_test();

        start_test("overflow");
        track = 1'b0;
        repeat (5) issue('1, kind_write);
        repeat (8) @(negedge clk);
        a_overflow_set: assert (overflow)
        else
        begin
            $display("Error overflow: expected 1, got %b", overflow);
            errors++;
        end
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 total_fails());
        if (total_fails() == 0 && tests_failed == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/tenant_pkg.sv
hdl/tenant_req_if.sv
hdl/offset_table.sv
hdl/tenant_tx_audit.sv
hdl/upstream_arbiter.sv
hdl/rsp_router.sv
hdl/tenant_shell.sv
verification/tenant_shell_chk.sv
verification/tb_tenant_shell.sv

// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert -j 0
TOP      := tb_tenant_shell
FILELIST := compile.f
RUNFLAGS := +verilator+error+limit+1000
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
